// ==== common/memory_map_pkg.sv ====
/* geometry of the word memory behind the spi slave
   1024 words of 32 bits split across two 16-bit banks
   addresses above ram_address_bits alias */
package memory_map_pkg;

	// stored word and one bank half
	localparam int word_bits = 32;
	localparam int bank_bits = 16;

	// depth and the address bits that are kept
	localparam int ram_address_bits = 10;
	localparam int ram_depth = 1 << ram_address_bits;

	// leds mirror the low bits of the last write
	localparam int led_bits = 3;

endpackage

// ==== common/spi_frame_pkg.sv ====
/* serial frame layout for the spi word memory
   a frame is command then address then data, each msb first
   any command other than cmd_write only reads */
package spi_frame_pkg;

	// one frame on the wire
	localparam int frame_bits = 56;

	// field widths in wire order
	localparam int command_bits = 8;
	localparam int address_bits = 16;
	localparam int data_bits = 32;

	// store the data word at the end of the frame
	localparam logic [command_bits-1:0] cmd_write = 8'h01;
	// read only with the data phase ignored
	localparam logic [command_bits-1:0] cmd_read = 8'h02;

endpackage

// ==== ram/ram_1k_32.sv ====
/* 1k x 32 word memory from two 16-bit banks
   both halves share address and enables
   read latency is one cycle and reset does not clear the contents */
`timescale 1ns/1ns
module ram_1k_32 (
	input  logic clock100,
	input  logic write_enable,
	input  logic [memory_map_pkg::ram_address_bits-1:0] write_address,
	input  logic [memory_map_pkg::word_bits-1:0] write_data,
	input  logic read_enable,
	input  logic [memory_map_pkg::ram_address_bits-1:0] read_address,
	output logic [memory_map_pkg::word_bits-1:0] read_data
);
	import memory_map_pkg::*;

	// upper half of each word
	ram_bank_1k_16 bank_high (
		.clock100      (clock100),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data[word_bits-1:bank_bits]),
		.read_enable   (read_enable),
		.read_address  (read_address),
		.read_data     (read_data[word_bits-1:bank_bits])
	);

	// lower half
	ram_bank_1k_16 bank_low (
		.clock100      (clock100),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data[bank_bits-1:0]),
		.read_enable   (read_enable),
		.read_address  (read_address),
		.read_data     (read_data[bank_bits-1:0])
	);

endmodule

// ==== ram/ram_bank_1k_16.sv ====
/* one behavioral 1k x 16 simple dual-port bank
   read data appears one cycle after read_enable
   read and write of the same address in one cycle returns the old word */
`timescale 1ns/1ns
module ram_bank_1k_16 (
	input  logic clock100,
	input  logic write_enable,
	input  logic [memory_map_pkg::ram_address_bits-1:0] write_address,
	input  logic [memory_map_pkg::bank_bits-1:0] write_data,
	input  logic read_enable,
	input  logic [memory_map_pkg::ram_address_bits-1:0] read_address,
	output logic [memory_map_pkg::bank_bits-1:0] read_data
);
	import memory_map_pkg::*;

	logic [bank_bits-1:0] mem [ram_depth];

	// write port
	always_ff @(posedge clock100) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

	// registered read that holds its last value otherwise
	always_ff @(posedge clock100) begin
		if (read_enable) begin
			read_data <= mem[read_address];
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run spi_ram_tb with verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module spi_ram_tb -f sources.f

./obj_dir/Vspi_ram_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation finished without errors"

// ==== sim/spi_ram_checker.sv ====
/* protocol timing checks attached to spi_ram_top by bind
   relies on the internal net names of the top level
   violations counts every failed assertion */
`timescale 1ns/1ns
module spi_ram_checker (
	input  logic clock100,
	input  logic reset1,
	input  logic miso,
	input  logic [memory_map_pkg::led_bits-1:0] leds,
	input  logic address_valid,
	input  logic tx_load,
	input  logic frame_valid,
	input  logic [spi_frame_pkg::command_bits-1:0] command,
	input  logic write_enable
);
	import spi_frame_pkg::*;

	// bumped by each failing assertion
	int unsigned violations = 0;

	// frame that asks for a store
	logic write_frame;
	assign write_frame = frame_valid && (command == cmd_write);

	// outputs cleared from the first reset edge on
	reset_outputs_low: assert property (@(posedge clock100)
		reset1 |=> (miso == 1'b0 && leds == '0))
	else begin
		violations++;
		$error("miso or leds not low during reset");
	end

	// read data handed back exactly 2 cycles after the address
	load_after_address: assert property (@(posedge clock100) disable iff (reset1)
		tx_load == $past(address_valid, 2))
	else begin
		violations++;
		$error("tx_load not 2 cycles after address_valid");
	end

	// store issued exactly 1 cycle after a write frame
	write_after_frame: assert property (@(posedge clock100) disable iff (reset1)
		write_enable == $past(write_frame))
	else begin
		violations++;
		$error("write_enable not 1 cycle after a write frame");
	end

endmodule

bind spi_ram_top spi_ram_checker chk0 (
	.clock100      (clock100),
	.reset1        (reset1),
	.miso          (miso),
	.leds          (leds),
	.address_valid (address_valid),
	.tx_load       (tx_load),
	.frame_valid   (frame_valid),
	.command       (command),
	.write_enable  (write_enable)
);

// ==== sim/spi_ram_tb.sv ====
/* spi mode 0 master driving spi_ram_top with sclk half periods of 4 clock100 cycles
   reads are compared with a 1024-word model where addresses alias modulo 1024
   only addresses written earlier in the run are read back */
`timescale 1ns/1ns
module spi_ram_tb;
	import spi_frame_pkg::*;
	import memory_map_pkg::*;

	localparam int clock_half = 50;
	// drive point after each rising edge
	localparam int drive_delay = 10;
	localparam int sclk_half_cycles = 4;
	localparam int random_writes = 64;
	// frames in the whole sequence with room for 20 idle cycles each around the bits
	localparam int frame_count = 2 * random_writes + 9;
	localparam int timeout_cycles = frame_count * (frame_bits * 8 + 20) + 1000;

	logic clock100;
	logic reset1;
	logic sclk;
	logic mosi;
	logic ssel_n;
	logic miso;
	logic [led_bits-1:0] leds;

	// reference memory and led state
	logic [word_bits-1:0] model [ram_depth];
	logic [led_bits-1:0] expected_leds;
	logic [address_bits-1:0] fill_address [random_writes];
	integer seed;

	spi_ram_top dut0 (
		.clock100 (clock100),
		.reset1   (reset1),
		.sclk     (sclk),
		.mosi     (mosi),
		.ssel_n   (ssel_n),
		.miso     (miso),
		.leds     (leds)
	);

	initial begin
		clock100 = 1'b0;
		forever #clock_half clock100 = ~clock100;
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string test_name,
		input logic [word_bits-1:0] expected, input logic [word_bits-1:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s: expected %08h, actual %08h",
				test_name, expected, actual);
			abort_run();
		end
	endtask

	// n rising edges and then a few ns past the last one
	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock100);
		#drive_delay;
	endtask

	// one frame msb first that is cut short when bits_sent < frame_bits
	task automatic spi_frame(
		input logic [command_bits-1:0] cmd,
		input logic [address_bits-1:0] addr,
		input logic [data_bits-1:0] wdata,
		input int bits_sent,
		output logic [data_bits-1:0] rdata
	);
		logic [frame_bits-1:0] frame;
		int i;
		frame = {cmd, addr, wdata};
		rdata = '0;
		wait_cycles(1);
		ssel_n = 1'b0;
		mosi = frame[frame_bits-1];
		for (i = 0; i < bits_sent; i++) begin
			wait_cycles(sclk_half_cycles);
			sclk = 1'b1;
			// miso moved on the previous fall and the last 32 bits are the data phase
			rdata = {rdata[data_bits-2:0], miso};
			wait_cycles(sclk_half_cycles);
			sclk = 1'b0;
			if (i < frame_bits - 1) begin
				mosi = frame[frame_bits-2-i];
			end
		end
		wait_cycles(sclk_half_cycles);
		ssel_n = 1'b1;
		wait_cycles(sclk_half_cycles);
	endtask

	// leds of an accepted write settle well before the frame task returns
	task automatic write_word(input string test_name, input logic [address_bits-1:0] addr,
		input logic [data_bits-1:0] wdata, output logic [data_bits-1:0] old_word);
		spi_frame(cmd_write, addr, wdata, frame_bits, old_word);
		model[addr[ram_address_bits-1:0]] = wdata;
		expected_leds = wdata[led_bits-1:0];
		check_value({test_name, " leds"}, 32'(expected_leds), 32'(leds));
	endtask

	task automatic read_check(input string test_name, input logic [address_bits-1:0] addr);
		logic [data_bits-1:0] got;
		// data phase of a read carries junk
		spi_frame(cmd_read, addr, 32'($random(seed)), frame_bits, got);
		check_value(test_name, model[addr[ram_address_bits-1:0]], got);
		check_value({test_name, " leds"}, 32'(expected_leds), 32'(leds));
	endtask

	initial begin
		logic [data_bits-1:0] old_word;
		logic [data_bits-1:0] expected_old;
		logic [address_bits-1:0] addr;
		int n;
		seed = 32'h6230;
		reset1 = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		ssel_n = 1'b1;
		expected_leds = '0;
		repeat (5) @(posedge clock100);
		#drive_delay;
		reset1 = 1'b0;
		check_value("reset leds", '0, 32'(leds));
		check_value("reset miso", '0, 32'(miso));

		// write then read back directly and through an aliased address
		write_word("write then read", 16'h8123, 32'hdead_beef, old_word);
		read_check("write then read", 16'h8123);
		read_check("alias read", 16'h0123);

		// random fill where addresses may alias each other
		for (n = 0; n < random_writes; n++) begin
			fill_address[n] = 16'($random(seed));
			write_word("random fill", fill_address[n], 32'($random(seed)), old_word);
		end
		for (n = 0; n < random_writes; n++) begin
			read_check("random read back", fill_address[n]);
		end

		// write frame shifts out the word it replaces
		addr = fill_address[0];
		expected_old = model[addr[ram_address_bits-1:0]];
		write_word("old data on write", addr, 32'h5a5a_c3c3, old_word);
		check_value("old data on write", expected_old, old_word);
		read_check("old data on write", addr);

		// unknown command reads but does not store
		addr = fill_address[1];
		expected_old = model[addr[ram_address_bits-1:0]];
		spi_frame(8'h7e, addr, ~expected_old, frame_bits, old_word);
		check_value("other command data phase", expected_old, old_word);
		read_check("other command", addr);

		// write cut off after 40 bits
		addr = fill_address[2];
		expected_old = model[addr[ram_address_bits-1:0]];
		spi_frame(cmd_write, addr, ~expected_old, 40, old_word);
		read_check("aborted frame", addr);

		if (dut0.chk0.violations == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("protocol assertions failed during the run");
			abort_run();
		end
	end

	// checker failures end the run at once
	always @(posedge clock100) begin
		if (dut0.chk0.violations != 0) begin
			$display("a protocol assertion in the checker failed");
			abort_run();
		end
	end

	// watchdog
	initial begin
		repeat (timeout_cycles) @(posedge clock100);
		$display("timeout: test sequence did not finish in %0d cycles", timeout_cycles);
		abort_run();
	end

endmodule

// ==== sources.f ====
common/spi_frame_pkg.sv
common/memory_map_pkg.sv
ram/ram_bank_1k_16.sv
ram/ram_1k_32.sv
spi/spi_slave_frame.sv
verilog/ram_access_ctrl.sv
verilog/spi_ram_top.sv
sim/spi_ram_checker.sv
sim/spi_ram_tb.sv

// ==== spi/spi_slave_frame.sv ====
/* spi mode 0 slave with msb first and ssel_n active low
   sclk half period must be at least 4 clock100 cycles
   a frame cut short by ssel_n is dropped without any report */
`timescale 1ns/1ns
module spi_slave_frame (
	input  logic clock100,
	input  logic reset1,
	input  logic sclk,
	input  logic mosi,
	input  logic ssel_n,
	input  logic [spi_frame_pkg::data_bits-1:0] tx_word,
	input  logic tx_load,
	output logic miso,
	output logic address_valid,
	output logic frame_valid,
	output logic [spi_frame_pkg::command_bits-1:0] command,
	output logic [spi_frame_pkg::address_bits-1:0] address,
	output logic [spi_frame_pkg::data_bits-1:0] data
);
	import spi_frame_pkg::*;

	// two flops per line into clock100
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] ssel_sync;
	// previous synced level for edge detection
	logic sclk_last;
	logic ssel_last;

	logic sclk_rise;
	logic sclk_fall;
	logic ssel_rise;
	logic selected;

	// rising edges seen so far in this frame
	logic [5:0] bit_count;
	logic address_done;
	logic last_bit;
	logic data_phase;

	logic [frame_bits-1:0] rx_shift;
	logic [frame_bits-1:0] rx_next;
	logic [data_bits-1:0] tx_shift;

	always_ff @(posedge clock100) begin
		if (reset1) begin
			// idle bus has sclk low and ssel_n high
			sclk_sync <= 2'b00;
			ssel_sync <= 2'b11;
			sclk_last <= 1'b0;
			ssel_last <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			ssel_sync <= {ssel_sync[0], ssel_n};
			sclk_last <= sclk_sync[1];
			ssel_last <= ssel_sync[1];
		end
	end

	// data line aligned with sclk_sync[1]
	always_ff @(posedge clock100) begin
		mosi_sync <= {mosi_sync[0], mosi};
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_last;
	assign sclk_fall = ~sclk_sync[1] & sclk_last;
	assign ssel_rise = ssel_sync[1] & ~ssel_last;
	assign selected = ~ssel_sync[1];

	// 24th edge closes the address and the 56th the frame
	assign address_done = bit_count == 6'(command_bits + address_bits - 1);
	assign last_bit = bit_count == 6'(frame_bits - 1);
	// the fall after the 24th rise must keep bit 31 on miso
	assign data_phase = bit_count > 6'(command_bits + address_bits);

	assign rx_next = {rx_shift[frame_bits-2:0], mosi_sync[1]};

	always_ff @(posedge clock100) begin
		if (reset1) begin
			bit_count <= '0;
			address_valid <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			address_valid <= 1'b0;
			frame_valid <= 1'b0;
			if (ssel_rise) begin
				// early deselect loses the frame
				bit_count <= '0;
			end else if (selected && sclk_rise) begin
				if (last_bit) begin
					bit_count <= '0;
					frame_valid <= 1'b1;
				end else begin
					bit_count <= bit_count + 6'd1;
				end
				if (address_done) begin
					address_valid <= 1'b1;
				end
			end
		end
	end

	// receive shifter and field capture
	always_ff @(posedge clock100) begin
		if (selected && sclk_rise) begin
			rx_shift <= rx_next;
			if (address_done) begin
				command <= rx_next[address_bits +: command_bits];
				address <= rx_next[address_bits-1:0];
			end
			// command and address stay put until the next frame's 24th bit
			if (last_bit) begin
				data <= rx_next[data_bits-1:0];
			end
		end
	end

	// transmit shifter sends bit 31 first
	always_ff @(posedge clock100) begin
		if (reset1) begin
			tx_shift <= '0;
		end else if (ssel_rise) begin
			tx_shift <= '0;
		end else if (tx_load) begin
			tx_shift <= tx_word;
		end else if (selected && sclk_fall && data_phase) begin
			tx_shift <= {tx_shift[data_bits-2:0], 1'b0};
		end
	end

	assign miso = tx_shift[data_bits-1];

endmodule

// ==== verilog/ram_access_ctrl.sv ====
/* turns slave pulses into ram reads and writes
   only the low 10 address bits reach the ram
   read data goes back to the slave 2 cycles after address_valid */
`timescale 1ns/1ns
module ram_access_ctrl (
	input  logic clock100,
	input  logic reset1,
	input  logic address_valid,
	input  logic frame_valid,
	input  logic [spi_frame_pkg::command_bits-1:0] command,
	input  logic [spi_frame_pkg::address_bits-1:0] address,
	input  logic [spi_frame_pkg::data_bits-1:0] data,
	input  logic [memory_map_pkg::word_bits-1:0] read_data,
	output logic read_enable,
	output logic [memory_map_pkg::ram_address_bits-1:0] read_address,
	output logic write_enable,
	output logic [memory_map_pkg::ram_address_bits-1:0] write_address,
	output logic [memory_map_pkg::word_bits-1:0] write_data,
	output logic [spi_frame_pkg::data_bits-1:0] tx_word,
	output logic tx_load,
	output logic [memory_map_pkg::led_bits-1:0] leds
);
	import spi_frame_pkg::*;
	import memory_map_pkg::*;

	// ram read_data valid in this cycle
	logic read_pending;
	logic write_request;

	// read straight off the address pulse with the upper bits dropped
	assign read_enable = address_valid;
	assign read_address = address[ram_address_bits-1:0];

	assign write_request = frame_valid && (command == cmd_write);

	always_ff @(posedge clock100) begin
		if (reset1) begin
			read_pending <= 1'b0;
			tx_load <= 1'b0;
			write_enable <= 1'b0;
			leds <= '0;
		end else begin
			read_pending <= read_enable;
			tx_load <= read_pending;
			write_enable <= write_request;
			// leds follow the word being stored
			if (write_request) begin
				leds <= data[led_bits-1:0];
			end
		end
	end

	// payload registers
	always_ff @(posedge clock100) begin
		if (read_pending) begin
			tx_word <= read_data;
		end
		if (write_request) begin
			write_address <= address[ram_address_bits-1:0];
			write_data <= data;
		end
	end

endmodule

// ==== verilog/spi_ram_top.sv ====
/* spi attached 1k x 32 word memory
   host is an spi mode 0 master with sclk half periods of at least 4 clock100 cycles
   reset1 is synchronous and comes from outside */
`timescale 1ns/1ns
module spi_ram_top (
	input  logic clock100,
	input  logic reset1,
	input  logic sclk,
	input  logic mosi,
	input  logic ssel_n,
	output logic miso,
	output logic [memory_map_pkg::led_bits-1:0] leds
);
	import spi_frame_pkg::*;
	import memory_map_pkg::*;

	// slave to controller
	logic address_valid;
	logic frame_valid;
	logic [command_bits-1:0] command;
	logic [address_bits-1:0] address;
	logic [data_bits-1:0] data;

	// controller to slave
	logic [data_bits-1:0] tx_word;
	logic tx_load;

	// controller and ram
	logic read_enable;
	logic [ram_address_bits-1:0] read_address;
	logic [word_bits-1:0] read_data;
	logic write_enable;
	logic [ram_address_bits-1:0] write_address;
	logic [word_bits-1:0] write_data;

	spi_slave_frame slave0 (
		.clock100      (clock100),
		.reset1        (reset1),
		.sclk          (sclk),
		.mosi          (mosi),
		.ssel_n        (ssel_n),
		.tx_word       (tx_word),
		.tx_load       (tx_load),
		.miso          (miso),
		.address_valid (address_valid),
		.frame_valid   (frame_valid),
		.command       (command),
		.address       (address),
		.data          (data)
	);

	ram_access_ctrl ctrl0 (
		.clock100      (clock100),
		.reset1        (reset1),
		.address_valid (address_valid),
		.frame_valid   (frame_valid),
		.command       (command),
		.address       (address),
		.data          (data),
		.read_data     (read_data),
		.read_enable   (read_enable),
		.read_address  (read_address),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.tx_word       (tx_word),
		.tx_load       (tx_load),
		.leds          (leds)
	);

	ram_1k_32 ram0 (
		.clock100      (clock100),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.read_enable   (read_enable),
		.read_address  (read_address),
		.read_data     (read_data)
	);

endmodule
